// ==== i2c_bus_pkg.sv ====
/*
  I2C bus definitions for the thermometer slave.
  Device address code, byte width and the slave
  sequencing states.
*/
`default_nettype none

package i2c_bus_pkg;

  // Upper address nibble, the pins A2..A0 complete the 7-bit address
  localparam logic [3:0] DEVICE_CODE = 4'h9;

  localparam int BYTE_W = 8;

  typedef enum logic [2:0] {
    ST_IDLE,    // Bus free or not yet started
    ST_ADDR,    // Shifting in the address byte
    ST_WRITE,   // Command and data bytes from the master
    ST_READ,    // Driving read bytes out
    ST_IGNORE   // Other device, or read ended by NACK
  } slave_state_t;

endpackage

`default_nettype wire

// ==== thermo_pkg.sv ====
/*
  Thermometer definitions.
  Command opcodes, register temperature format, reset
  values, conversion time and the config/status bit map.
*/
`default_nettype none

package thermo_pkg;

  typedef enum logic [7:0] {
    CMD_STOP  = 8'h22,
    CMD_TH    = 8'hA1,
    CMD_TL    = 8'hA2,
    CMD_CNT   = 8'hA8,
    CMD_SLP   = 8'hA9,
    CMD_TMP   = 8'hAA,
    CMD_CFG   = 8'hAC,
    CMD_START = 8'hEE
  } cmd_t;

  // Whole degrees in the upper byte, half degree in bit 7
  typedef logic signed [15:0] temp_t;

  localparam int TEMP_IN_W = 9;   // Half-degree sensor input

  localparam temp_t TEMP_RESET = 16'h1700;   // 23 C
  localparam temp_t TH_RESET   = 16'h5000;
  localparam temp_t TL_RESET   = 16'h4B00;

  localparam int TEMP_MAX = 125;
  localparam int TEMP_MIN = -55;

  localparam int CONV_CYCLES = 64;

  // Config/status byte
  localparam int CFG_DONE     = 7;
  localparam int CFG_THF      = 6;
  localparam int CFG_TLF      = 5;
  localparam int CFG_NVB      = 4;
  localparam int CFG_POL      = 1;
  localparam int CFG_ONE_SHOT = 0;

endpackage

`default_nettype wire

// ==== sensor_ifs.sv ====
/*
  Internal connections of the thermometer.
  bus_event_if carries the synchronized line events,
  reg_access_if the byte strobes between slave and registers.
*/
`timescale 1ns/1ps
`default_nettype none

interface bus_event_if;
  logic scl_rise;
  logic scl_fall;
  logic start;
  logic stop;
  logic sda_bit;   // Synchronized SDA level

  modport source (output scl_rise, scl_fall, start, stop, sda_bit);
  modport sink   (input  scl_rise, scl_fall, start, stop, sda_bit);
endinterface

interface reg_access_if;
  logic                          cmd_valid;
  logic [i2c_bus_pkg::BYTE_W-1:0] cmd_byte;
  logic                          wr_valid;
  logic [i2c_bus_pkg::BYTE_W-1:0] wr_data;
  logic                          wr_index;
  logic                          rd_take;
  logic                          rd_index;
  logic                          xfer_end;
  logic [i2c_bus_pkg::BYTE_W-1:0] rd_data;   // Combinational from the registers

  modport master (
    output cmd_valid, cmd_byte, wr_valid, wr_data, wr_index,
    output rd_take, rd_index, xfer_end,
    input  rd_data
  );
  modport target (
    input  cmd_valid, cmd_byte, wr_valid, wr_data, wr_index,
    input  rd_take, rd_index, xfer_end,
    output rd_data
  );
endinterface

`default_nettype wire

// ==== i2c_line_monitor.sv ====
/*
  I2C line monitor.
  Brings SCL and SDA into the int_clk domain and flags
  SCL edges and start/stop conditions as one-cycle strobes.
*/
`timescale 1ns/1ps
`default_nettype none

module i2c_line_monitor (
  input  wire         int_clk,
  input  wire         rst_n,
  input  wire         scl,
  input  wire         sda,
  bus_event_if.source ev
);

  logic [1:0] scl_sync;
  logic [1:0] sda_sync;
  logic       scl_q;   // Previous synchronized level
  logic       sda_q;

  always_ff @(posedge int_clk or negedge rst_n) begin
    if (!rst_n) begin
      scl_sync    <= 2'b11;   // Idle bus is high
      sda_sync    <= 2'b11;
      scl_q       <= 1'b1;
      sda_q       <= 1'b1;
      ev.scl_rise <= 1'b0;
      ev.scl_fall <= 1'b0;
      ev.start    <= 1'b0;
      ev.stop     <= 1'b0;
    end else begin
      scl_sync <= {scl_sync[0], scl};
      sda_sync <= {sda_sync[0], sda};
      scl_q    <= scl_sync[1];
      sda_q    <= sda_sync[1];

      ev.scl_rise <= scl_sync[1] & ~scl_q;
      ev.scl_fall <= ~scl_sync[1] & scl_q;
      // SDA edge with SCL high on both samples
      ev.start <= scl_sync[1] & scl_q & sda_q & ~sda_sync[1];
      ev.stop  <= scl_sync[1] & scl_q & ~sda_q & sda_sync[1];
    end
  end

  assign ev.sda_bit = sda_q;   // Aligned with the strobes

  a_start_stop_excl: assert property (@(posedge int_clk) disable iff (!rst_n)
    !(ev.start && ev.stop))
    else $error("start and stop flagged in the same cycle");

endmodule

`default_nettype wire

// ==== i2c_slave_port.sv ====
/*
  I2C slave port.
  Matches the device address, acknowledges written bytes,
  turns them into command and data strobes and shifts read
  bytes out MSB first through the open-drain enable.
*/
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_port (
  input  wire          int_clk,
  input  wire          rst_n,
  input  wire [2:0]    addr_pins,
  bus_event_if.sink    ev,
  reg_access_if.master ra,
  output logic         sda_oe
);

  i2c_bus_pkg::slave_state_t state;

  logic [3:0]                     bit_cnt;   // SCL rises in this byte
  logic [i2c_bus_pkg::BYTE_W-1:0] sr;
  logic                           rw;        // R/W bit of the address
  logic                           got_cmd;   // Command byte already taken
  logic                           idx;       // Data byte index, saturates at 1
  logic                           active;

  assign active      = state != i2c_bus_pkg::ST_IDLE && state != i2c_bus_pkg::ST_IGNORE;
  assign ra.wr_index = idx;
  assign ra.rd_index = idx;

  always_ff @(posedge int_clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= i2c_bus_pkg::ST_IDLE;
      bit_cnt     <= '0;
      sr          <= '0;
      rw          <= 1'b0;
      got_cmd     <= 1'b0;
      idx         <= 1'b0;
      sda_oe      <= 1'b0;
      ra.cmd_valid <= 1'b0;
      ra.cmd_byte  <= '0;
      ra.wr_valid  <= 1'b0;
      ra.wr_data   <= '0;
      ra.rd_take   <= 1'b0;
      ra.xfer_end  <= 1'b0;
    end else begin
      ra.cmd_valid <= 1'b0;
      ra.wr_valid  <= 1'b0;
      ra.rd_take   <= 1'b0;
      ra.xfer_end  <= 1'b0;
      if (ra.wr_valid || ra.rd_take)
        idx <= 1'b1;

      if (ev.stop) begin
        state       <= i2c_bus_pkg::ST_IDLE;
        sda_oe      <= 1'b0;
        ra.xfer_end <= state != i2c_bus_pkg::ST_IDLE;
      end else if (ev.start) begin   // Also a repeated start
        state       <= i2c_bus_pkg::ST_ADDR;
        bit_cnt     <= '0;
        sda_oe      <= 1'b0;
        ra.xfer_end <= state != i2c_bus_pkg::ST_IDLE;
      end else if (active && ev.scl_rise) begin
        sr      <= {sr[i2c_bus_pkg::BYTE_W-2:0], ev.sda_bit};
        bit_cnt <= bit_cnt + 1'b1;
      end else if (active && ev.scl_fall) begin
        if (bit_cnt == i2c_bus_pkg::BYTE_W) begin
          // Ninth bit begins
          case (state)
            i2c_bus_pkg::ST_ADDR: begin
              if (sr[i2c_bus_pkg::BYTE_W-1:1] == {i2c_bus_pkg::DEVICE_CODE, addr_pins}) begin
                sda_oe  <= 1'b1;
                rw      <= sr[0];
                got_cmd <= 1'b0;
                idx     <= 1'b0;
              end else begin
                state <= i2c_bus_pkg::ST_IGNORE;   // Not our address
              end
            end
            i2c_bus_pkg::ST_WRITE: begin
              sda_oe <= 1'b1;
              if (got_cmd) begin
                ra.wr_valid <= 1'b1;
                ra.wr_data  <= sr;
              end else begin
                ra.cmd_valid <= 1'b1;
                ra.cmd_byte  <= sr;
                got_cmd      <= 1'b1;
              end
            end
            default: sda_oe <= 1'b0;   // Read, master drives ACK
          endcase
        end else if (bit_cnt == i2c_bus_pkg::BYTE_W + 1) begin
          // Ninth bit ends
          bit_cnt <= '0;
          if (state == i2c_bus_pkg::ST_WRITE || (state == i2c_bus_pkg::ST_ADDR && !rw)) begin
            state  <= i2c_bus_pkg::ST_WRITE;
            sda_oe <= 1'b0;
          end else if (state == i2c_bus_pkg::ST_ADDR || !sr[0]) begin
            // Address acked for read, or master ACK, so load the next byte
            state      <= i2c_bus_pkg::ST_READ;
            sr         <= ra.rd_data;
            sda_oe     <= ~ra.rd_data[i2c_bus_pkg::BYTE_W-1];
            ra.rd_take <= 1'b1;
          end else begin
            state  <= i2c_bus_pkg::ST_IGNORE;   // NACK ends the read
            sda_oe <= 1'b0;
          end
        end else if (state == i2c_bus_pkg::ST_READ) begin
          sda_oe <= ~sr[i2c_bus_pkg::BYTE_W-1];   // Next data bit, open drain
        end
      end
    end
  end

  a_idle_released: assert property (@(posedge int_clk) disable iff (!rst_n)
    state == i2c_bus_pkg::ST_IDLE |-> !sda_oe)
    else $error("SDA driven while the slave is idle");

endmodule

`default_nettype wire

// ==== sensor_registers.sv ====
/*
  Thermometer register file.
  Decodes the command byte, holds TH, TL and the config bits,
  issues conversion strobes and forms the read byte.
*/
`timescale 1ns/1ps
`default_nettype none

module sensor_registers (
  input  wire                int_clk,
  input  wire                rst_n,
  reg_access_if.target       ra,
  input  wire thermo_pkg::temp_t tmp,
  input  wire                done,
  input  wire                thf,
  input  wire                tlf,
  output thermo_pkg::temp_t  th,
  output thermo_pkg::temp_t  tl,
  output logic               pol,
  output logic               one_shot,
  output logic               conv_start_cmd,
  output logic               conv_stop_cmd,
  output logic               thf_clr,
  output logic               tlf_clr
);

  thermo_pkg::cmd_t cmd_q;
  logic             cmd_new;     // Command written in the current transfer
  logic             cfg_wr;
  logic             status_rd;
  logic             done_seen;   // Holds a short continuous-mode DONE for polling
  logic [7:0]       tmp_lo_q;    // TMP low byte taken with the high byte
  logic [7:0]       status;

  assign cfg_wr    = ra.wr_valid && cmd_q == thermo_pkg::CMD_CFG && !ra.wr_index;
  assign status_rd = ra.rd_take && cmd_q == thermo_pkg::CMD_CFG;

  always_ff @(posedge int_clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_q          <= thermo_pkg::CMD_TMP;
      cmd_new        <= 1'b0;
      th             <= thermo_pkg::TH_RESET;
      tl             <= thermo_pkg::TL_RESET;
      pol            <= 1'b0;
      one_shot       <= 1'b0;
      conv_start_cmd <= 1'b0;
      conv_stop_cmd  <= 1'b0;
      thf_clr        <= 1'b0;
      tlf_clr        <= 1'b0;
      done_seen      <= 1'b0;
    end else begin
      // START and STOP act when the transfer closes
      conv_start_cmd <= ra.xfer_end && cmd_new && cmd_q == thermo_pkg::CMD_START;
      conv_stop_cmd  <= ra.xfer_end && cmd_new && cmd_q == thermo_pkg::CMD_STOP;
      thf_clr        <= cfg_wr && !ra.wr_data[thermo_pkg::CFG_THF];
      tlf_clr        <= cfg_wr && !ra.wr_data[thermo_pkg::CFG_TLF];

      if (conv_start_cmd)
        done_seen <= 1'b0;   // Stale DONE from an older conversion
      else
        done_seen <= done || (done_seen && !status_rd);

      if (ra.cmd_valid) begin
        cmd_q   <= thermo_pkg::cmd_t'(ra.cmd_byte);
        cmd_new <= 1'b1;
      end else if (ra.xfer_end) begin
        cmd_new <= 1'b0;
      end

      if (ra.wr_valid) begin
        case (cmd_q)
          thermo_pkg::CMD_TH:
            if (ra.wr_index) th[7:0] <= ra.wr_data;
            else             th[15:8] <= ra.wr_data;
          thermo_pkg::CMD_TL:
            if (ra.wr_index) tl[7:0] <= ra.wr_data;
            else             tl[15:8] <= ra.wr_data;
          thermo_pkg::CMD_CFG:
            if (!ra.wr_index) begin
              pol      <= ra.wr_data[thermo_pkg::CFG_POL];
              one_shot <= ra.wr_data[thermo_pkg::CFG_ONE_SHOT];
            end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge int_clk) begin
    if (ra.rd_take && !ra.rd_index)
      tmp_lo_q <= tmp[7:0];
  end

  always_comb begin
    status                           = '0;
    status[thermo_pkg::CFG_DONE]     = done_seen;
    status[thermo_pkg::CFG_THF]      = thf;
    status[thermo_pkg::CFG_TLF]      = tlf;
    status[thermo_pkg::CFG_NVB]      = 1'b0;   // No EEPROM, never busy
    status[thermo_pkg::CFG_POL]      = pol;
    status[thermo_pkg::CFG_ONE_SHOT] = one_shot;
  end

  always_comb begin
    case (cmd_q)
      thermo_pkg::CMD_TH:  ra.rd_data = ra.rd_index ? th[7:0] : th[15:8];
      thermo_pkg::CMD_TL:  ra.rd_data = ra.rd_index ? tl[7:0] : tl[15:8];
      thermo_pkg::CMD_TMP: ra.rd_data = ra.rd_index ? tmp_lo_q : tmp[15:8];
      thermo_pkg::CMD_CFG: ra.rd_data = status;
      default:             ra.rd_data = 8'hFF;   // CNT, SLP and unknown
    endcase
  end

endmodule

`default_nettype wire

// ==== temp_converter.sv ====
/*
  Temperature converter.
  Times each conversion with a cycle counter, then clamps
  the half-degree input and loads the TMP register.
*/
`timescale 1ns/1ps
`default_nettype none

module temp_converter (
  input  wire                                    int_clk,
  input  wire                                    rst_n,
  input  wire signed [thermo_pkg::TEMP_IN_W-1:0] temp_in,
  input  wire                                    conv_start_cmd,
  input  wire                                    conv_stop_cmd,
  input  wire                                    one_shot,
  output thermo_pkg::temp_t                      tmp,
  output logic                                   done
);

  typedef enum logic {CV_IDLE, CV_BUSY} conv_state_t;

  conv_state_t                                 state;
  logic [$clog2(thermo_pkg::CONV_CYCLES)-1:0]  cnt;
  logic                                        stopped;   // STOP seen since the last START
  logic                                        start_now;
  int                                          t_half;
  thermo_pkg::temp_t                           tmp_next;

  // One-shot waits for START, continuous restarts right away
  assign start_now = state == CV_IDLE &&
                     (conv_start_cmd || (!one_shot && !stopped && !conv_stop_cmd));

  always_comb begin
    t_half = int'(temp_in);
    if (t_half > 2 * thermo_pkg::TEMP_MAX)
      t_half = 2 * thermo_pkg::TEMP_MAX;
    else if (t_half < 2 * thermo_pkg::TEMP_MIN)
      t_half = 2 * thermo_pkg::TEMP_MIN;
  end

  // Upper byte whole degrees, bit 7 the half
  assign tmp_next = {t_half[thermo_pkg::TEMP_IN_W-1:1], t_half[0], 7'b0};

  always_ff @(posedge int_clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= CV_BUSY;   // Continuous conversion from reset
      cnt     <= '0;
      done    <= 1'b0;
      stopped <= 1'b0;
      tmp     <= thermo_pkg::TEMP_RESET;
    end else begin
      if (conv_stop_cmd)
        stopped <= 1'b1;
      else if (conv_start_cmd)
        stopped <= 1'b0;

      case (state)
        CV_IDLE: if (start_now) begin
          state <= CV_BUSY;
          cnt   <= '0;
          done  <= 1'b0;
        end
        CV_BUSY: if (cnt == thermo_pkg::CONV_CYCLES - 1) begin
          state <= CV_IDLE;
          done  <= 1'b1;
          tmp   <= tmp_next;
        end else begin
          cnt <= cnt + 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== thermostat.sv ====
/*
  Thermostat.
  Alarm with TH/TL hysteresis, the sticky THF and TLF flags
  and the TOUT pin with selectable polarity.
*/
`timescale 1ns/1ps
`default_nettype none

module thermostat (
  input  wire                    int_clk,
  input  wire                    rst_n,
  input  wire thermo_pkg::temp_t tmp,
  input  wire thermo_pkg::temp_t th,
  input  wire thermo_pkg::temp_t tl,
  input  wire                    pol,
  input  wire                    thf_clr,
  input  wire                    tlf_clr,
  output logic                   thf,
  output logic                   tlf,
  output logic                   tout
);

  logic alarm;
  logic too_hot;
  logic too_cold;

  assign too_hot  = tmp > th;   // Signed compare of the 16-bit format
  assign too_cold = tmp < tl;

  always_ff @(posedge int_clk or negedge rst_n) begin
    if (!rst_n) begin
      alarm <= 1'b0;
      thf   <= 1'b0;
      tlf   <= 1'b0;
    end else begin
      if (too_hot)
        alarm <= 1'b1;
      else if (too_cold)
        alarm <= 1'b0;   // Between TL and TH the alarm holds

      // A clear only sticks once the condition is gone
      if (too_hot)
        thf <= 1'b1;
      else if (thf_clr)
        thf <= 1'b0;

      if (too_cold)
        tlf <= 1'b1;
      else if (tlf_clr)
        tlf <= 1'b0;
    end
  end

  assign tout = pol ? alarm : ~alarm;

endmodule

`default_nettype wire

// ==== ds1621_top.sv ====
/*
  DS1621-style digital thermometer, top level.
  I2C slave with open-drain SDA enable, register file,
  temperature converter and thermostat output.
*/
`timescale 1ns/1ps
`default_nettype none

module ds1621_top (
  input  wire                                    int_clk,
  input  wire                                    rst_n,
  input  wire                                    scl,
  input  wire                                    sda,
  input  wire [2:0]                              addr_pins,
  input  wire signed [thermo_pkg::TEMP_IN_W-1:0] temp_in,
  output wire                                    sda_oe,
  output wire                                    tout
);

  bus_event_if  ev ();
  reg_access_if ra ();

  thermo_pkg::temp_t th;
  thermo_pkg::temp_t tl;
  thermo_pkg::temp_t tmp;
  logic              pol;
  logic              one_shot;
  logic              conv_start_cmd;
  logic              conv_stop_cmd;
  logic              thf_clr;
  logic              tlf_clr;
  logic              done;
  logic              thf;
  logic              tlf;

  i2c_line_monitor u_line_monitor (
    .int_clk (int_clk),
    .rst_n   (rst_n),
    .scl     (scl),
    .sda     (sda),
    .ev      (ev)
  );

  i2c_slave_port u_slave_port (
    .int_clk   (int_clk),
    .rst_n     (rst_n),
    .addr_pins (addr_pins),
    .ev        (ev),
    .ra        (ra),
    .sda_oe    (sda_oe)
  );

  sensor_registers u_registers (
    .int_clk        (int_clk),
    .rst_n          (rst_n),
    .ra             (ra),
    .tmp            (tmp),
    .done           (done),
    .thf            (thf),
    .tlf            (tlf),
    .th             (th),
    .tl             (tl),
    .pol            (pol),
    .one_shot       (one_shot),
    .conv_start_cmd (conv_start_cmd),
    .conv_stop_cmd  (conv_stop_cmd),
    .thf_clr        (thf_clr),
    .tlf_clr        (tlf_clr)
  );

  temp_converter u_converter (
    .int_clk        (int_clk),
    .rst_n          (rst_n),
    .temp_in        (temp_in),
    .conv_start_cmd (conv_start_cmd),
    .conv_stop_cmd  (conv_stop_cmd),
    .one_shot       (one_shot),
    .tmp            (tmp),
    .done           (done)
  );

  thermostat u_thermostat (
    .int_clk (int_clk),
    .rst_n   (rst_n),
    .tmp     (tmp),
    .th      (th),
    .tl      (tl),
    .pol     (pol),
    .thf_clr (thf_clr),
    .tlf_clr (tlf_clr),
    .thf     (thf),
    .tlf     (tlf),
    .tout    (tout)
  );

endmodule

`default_nettype wire

// ==== tb_ds1621.sv ====
/*
  Testbench for the DS1621-style thermometer.
  An I2C master model runs directed tests on address match,
  register access, conversion modes and the thermostat output.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_ds1621;

  localparam int CLK_PERIOD = 40;
  localparam int BIT_CYCLES = 8;          // SCL period in int_clk cycles
  localparam logic [2:0] PINS = 3'd5;
  // 400 transfers of 40 bits plus 20 conversions
  localparam int WATCHDOG_CYCLES =
    400 * 40 * BIT_CYCLES + 20 * (thermo_pkg::CONV_CYCLES + 1);

  logic                                    int_clk;
  logic                                    rst_n;
  logic                                    scl_drv;
  logic                                    sda_drv;   // Master side of the open-drain line
  logic [2:0]                              addr_pins;
  logic signed [thermo_pkg::TEMP_IN_W-1:0] temp_in;
  logic [15:0]                             lfsr_state;
  wire                                     sda_line;
  wire                                     sda_oe;
  wire                                     tout;

  assign sda_line = sda_drv & ~sda_oe;   // Wired AND with the slave pull-down

  ds1621_top DUT (
    .int_clk   (int_clk),
    .rst_n     (rst_n),
    .scl       (scl_drv),
    .sda       (sda_line),
    .addr_pins (addr_pins),
    .temp_in   (temp_in),
    .sda_oe    (sda_oe),
    .tout      (tout)
  );

  initial begin
    int_clk = 1'b0;
    forever #(CLK_PERIOD / 2) int_clk = ~int_clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("ERROR: watchdog expired, the run hung");
    $display("test failed");
    $fatal(1, "watchdog timeout");
  end

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, expected, actual);
      $display("test failed");
      $fatal(1, "stopping at the first error");
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge int_clk);
  endtask

  // 16-bit Galois LFSR, one step per bit
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = (value << 1) | lfsr_state[0];
    end
  endtask

  // Clamp to -55..125 C, whole degrees high, half degree in bit 7
  function automatic logic [15:0] expected_tmp(input int half_deg);
    int t;
    int half;
    int whole;
    t = half_deg;
    if (t > 2 * thermo_pkg::TEMP_MAX)
      t = 2 * thermo_pkg::TEMP_MAX;
    else if (t < 2 * thermo_pkg::TEMP_MIN)
      t = 2 * thermo_pkg::TEMP_MIN;
    half  = t & 1;
    whole = (t - half) / 2;
    return {whole[7:0], half[0], 7'b0};
  endfunction

  function automatic logic [7:0] addr_byte(input logic [2:0] pins, input logic rd);
    return {i2c_bus_pkg::DEVICE_CODE, pins, rd};
  endfunction

  task automatic set_temp(input int half_deg);
    temp_in = half_deg[thermo_pkg::TEMP_IN_W-1:0];
  endtask

  // One SCL period, entered and left with SCL low
  task automatic clock_bit(input logic drive, output logic sampled);
    wait_cycles(1);
    sda_drv = drive;
    wait_cycles(BIT_CYCLES / 2 - 1);
    scl_drv = 1'b1;
    wait_cycles(BIT_CYCLES / 2 - 1);
    sampled = sda_line;   // Late in the high phase
    wait_cycles(1);
    scl_drv = 1'b0;
  endtask

  // Also serves as repeated start
  task automatic bus_start();
    wait_cycles(1);
    sda_drv = 1'b1;
    wait_cycles(4);   // Slave ACK released before SCL rises
    scl_drv = 1'b1;
    wait_cycles(4);
    sda_drv = 1'b0;
    wait_cycles(4);
    scl_drv = 1'b0;
  endtask

  task automatic bus_stop();
    wait_cycles(1);
    sda_drv = 1'b0;
    wait_cycles(4);
    scl_drv = 1'b1;
    wait_cycles(4);
    sda_drv = 1'b1;
    wait_cycles(4);
  endtask

  task automatic write_byte(input logic [7:0] data, output logic ack);
    logic s;
    for (int i = 7; i >= 0; i--)
      clock_bit(data[i], s);
    clock_bit(1'b1, s);   // Slave pulls low to acknowledge
    ack = ~s;
  endtask

  task automatic read_byte(input logic ack, output logic [7:0] data);
    logic s;
    for (int i = 7; i >= 0; i--) begin
      clock_bit(1'b1, s);
      data[i] = s;
    end
    clock_bit(~ack, s);
  endtask

  task automatic reg_write(input string name, input logic [7:0] cmd, input int nbytes,
                           input logic [15:0] data);
    logic ack;
    bus_start();
    write_byte(addr_byte(PINS, 1'b0), ack);
    compare({name, " address ack"}, 1, ack);
    write_byte(cmd, ack);
    compare({name, " command ack"}, 1, ack);
    for (int i = nbytes - 1; i >= 0; i--) begin
      write_byte(data[8*i +: 8], ack);   // Upper byte first
      compare({name, " data ack"}, 1, ack);
    end
    bus_stop();
  endtask

  task automatic reg_read(input string name, input logic [7:0] cmd, input int nbytes,
                          output logic [15:0] data);
    logic       ack;
    logic [7:0] b;
    data = '0;
    bus_start();
    write_byte(addr_byte(PINS, 1'b0), ack);
    compare({name, " address ack"}, 1, ack);
    write_byte(cmd, ack);
    compare({name, " command ack"}, 1, ack);
    bus_start();
    write_byte(addr_byte(PINS, 1'b1), ack);
    compare({name, " read address ack"}, 1, ack);
    for (int i = nbytes - 1; i >= 0; i--) begin
      read_byte(i != 0, b);   // NACK on the last byte
      data[8*i +: 8] = b;
    end
    bus_stop();
  endtask

  task automatic read_status(input string name, output logic [7:0] s);
    logic [15:0] d;
    reg_read(name, thermo_pkg::CMD_CFG, 1, d);
    s = d[7:0];
  endtask

  // A DONE seen once, then a conversion that ran wholly after that read
  task automatic wait_conversion(input string name);
    logic [7:0] s;
    s = 8'h00;
    while (!s[thermo_pkg::CFG_DONE])
      read_status(name, s);
    s = 8'h00;
    while (!s[thermo_pkg::CFG_DONE])
      read_status(name, s);
  endtask

  task automatic address_match();
    logic        ack;
    logic [15:0] d;
    compare("reset sda_oe", 0, sda_oe);
    compare("reset tout", 1, tout);
    bus_start();
    write_byte(addr_byte(3'd2, 1'b0), ack);   // Wrong pins
    compare("wrong address nack", 0, ack);
    write_byte(thermo_pkg::CMD_TH, ack);
    compare("ignored command nack", 0, ack);
    write_byte(8'h12, ack);
    write_byte(8'h80, ack);
    bus_stop();
    reg_read("th after wrong address", thermo_pkg::CMD_TH, 2, d);
    compare("th after wrong address", thermo_pkg::TH_RESET, d);
    reg_write("th write", thermo_pkg::CMD_TH, 2, 16'h2D80);
    reg_read("th readback", thermo_pkg::CMD_TH, 2, d);
    compare("th readback", 16'h2D80, d);
  endtask

  task automatic register_access();
    logic [15:0] d;
    logic [7:0]  s;
    reg_write("tl write", thermo_pkg::CMD_TL, 2, 16'hF680);
    reg_read("tl readback", thermo_pkg::CMD_TL, 2, d);
    compare("tl readback", 16'hF680, d);
    reg_write("th write", thermo_pkg::CMD_TH, 2, 16'h7D00);
    reg_read("th readback", thermo_pkg::CMD_TH, 2, d);
    compare("th readback", 16'h7D00, d);
    reg_write("cfg write", thermo_pkg::CMD_CFG, 1, 16'h0003);
    read_status("cfg readback", s);
    compare("cfg pol", 1, s[thermo_pkg::CFG_POL]);
    compare("cfg one_shot", 1, s[thermo_pkg::CFG_ONE_SHOT]);
    compare("cfg nvb", 0, s[thermo_pkg::CFG_NVB]);
    reg_write("cfg clear", thermo_pkg::CMD_CFG, 1, 16'h0000);
    read_status("cfg cleared", s);
    compare("cfg pol cleared", 0, s[thermo_pkg::CFG_POL]);
    compare("cfg one_shot cleared", 0, s[thermo_pkg::CFG_ONE_SHOT]);
    reg_read("cnt read", thermo_pkg::CMD_CNT, 1, d);
    compare("cnt read", 16'h00FF, d);
    reg_read("slp read", thermo_pkg::CMD_SLP, 1, d);
    compare("slp read", 16'h00FF, d);
  endtask

  task automatic continuous_conversion();
    int          r;
    int          half_deg;
    logic [15:0] d;
    for (int n = 0; n < 12; n++) begin
      if (n == 10)
        half_deg = 254;    // Above 125 C
      else if (n == 11)
        half_deg = -256;   // Below -55 C
      else begin
        take_bits(thermo_pkg::TEMP_IN_W, r);
        half_deg = (r >= 256) ? r - 512 : r;
      end
      set_temp(half_deg);
      wait_conversion("continuous done");
      reg_read("continuous tmp", thermo_pkg::CMD_TMP, 2, d);
      compare($sformatf("continuous tmp for %0d half degrees", half_deg),
              expected_tmp(half_deg), d);
    end
  endtask

  task automatic one_shot_and_stop();
    logic [7:0]  s;
    logic [15:0] d;
    set_temp(60);
    wait_conversion("one-shot setup");
    reg_write("one-shot cfg", thermo_pkg::CMD_CFG, 1, 16'h0001);
    read_status("one-shot settle", s);   // Running conversion ends first
    set_temp(-21);
    reg_read("one-shot hold", thermo_pkg::CMD_TMP, 2, d);
    compare("one-shot tmp before start", expected_tmp(60), d);
    read_status("one-shot idle", s);
    reg_read("one-shot hold again", thermo_pkg::CMD_TMP, 2, d);
    compare("one-shot tmp still held", expected_tmp(60), d);
    reg_write("start command", thermo_pkg::CMD_START, 0, 16'h0000);
    read_status("one-shot done", s);
    compare("one-shot done after start", 1, s[thermo_pkg::CFG_DONE]);
    reg_read("one-shot result", thermo_pkg::CMD_TMP, 2, d);
    compare("one-shot tmp after start", expected_tmp(-21), d);

    reg_write("continuous cfg", thermo_pkg::CMD_CFG, 1, 16'h0000);
    set_temp(45);
    wait_conversion("before stop");
    reg_read("before stop", thermo_pkg::CMD_TMP, 2, d);
    compare("tmp before stop", expected_tmp(45), d);
    reg_write("stop command", thermo_pkg::CMD_STOP, 0, 16'h0000);
    read_status("stop settle", s);
    set_temp(-7);
    read_status("stopped", s);
    read_status("stopped", s);
    reg_read("after stop", thermo_pkg::CMD_TMP, 2, d);
    compare("tmp frozen after stop", expected_tmp(45), d);
    reg_write("restart command", thermo_pkg::CMD_START, 0, 16'h0000);
    wait_conversion("restart");
    reg_read("after restart", thermo_pkg::CMD_TMP, 2, d);
    compare("tmp after restart", expected_tmp(-7), d);
  endtask

  task automatic thermostat_alarm(input logic pol);
    logic [7:0] s;
    reg_write("thermostat th", thermo_pkg::CMD_TH, 2, 16'h1E00);   // 30 C
    reg_write("thermostat tl", thermo_pkg::CMD_TL, 2, 16'h1400);   // 20 C
    reg_write("thermostat cfg", thermo_pkg::CMD_CFG, 1, {14'b0, pol, 1'b0});
    set_temp(70);
    wait_conversion("thermostat 35 C");
    compare("tout at 35 C", pol, tout);
    read_status("thermostat 35 C", s);
    compare("thf at 35 C", 1, s[thermo_pkg::CFG_THF]);
    set_temp(50);
    wait_conversion("thermostat 25 C");
    compare("tout held at 25 C", pol, tout);
    set_temp(30);
    wait_conversion("thermostat 15 C");
    compare("tout at 15 C", !pol, tout);
    read_status("thermostat 15 C", s);
    compare("tlf at 15 C", 1, s[thermo_pkg::CFG_TLF]);
    set_temp(50);   // Neither flag condition true
    wait_conversion("thermostat back to 25 C");
    compare("tout idle at 25 C", !pol, tout);
    reg_write("flag clear", thermo_pkg::CMD_CFG, 1, {14'b0, pol, 1'b0});
    read_status("flag clear", s);
    compare("thf cleared", 0, s[thermo_pkg::CFG_THF]);
    compare("tlf cleared", 0, s[thermo_pkg::CFG_TLF]);
  endtask

  initial begin
    rst_n      = 1'b0;
    scl_drv    = 1'b1;
    sda_drv    = 1'b1;
    addr_pins  = PINS;
    temp_in    = 9'sd46;   // 23 C
    lfsr_state = 16'd62013;
    repeat (2) @(negedge int_clk);
    rst_n = 1'b1;
    wait_cycles(2);

    address_match();
    register_access();
    continuous_conversion();
    one_shot_and_stop();
    thermostat_alarm(1'b0);
    thermostat_alarm(1'b1);

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
i2c_bus_pkg.sv
thermo_pkg.sv
sensor_ifs.sv
i2c_line_monitor.sv
i2c_slave_port.sv
sensor_registers.sv
temp_converter.sv
thermostat.sv
ds1621_top.sv
tb_ds1621.sv
